// File: verilog/rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// widths shared by the whole slice
`define XLEN 32     // data and pc width
`define REGW 5      // register address width

// base opcodes, instr[6:0]
`define OP_LOAD   7'b0000011  // lw
`define OP_STORE  7'b0100011  // sw
`define OP_RTYPE  7'b0110011  // register-register ops and mul
`define OP_ITYPE  7'b0010011  // addi
`define OP_BRANCH 7'b1100011  // beq, bne
`define OP_JAL    7'b1101111
`define OP_LUI    7'b0110111

`endif

// File: verilog/rvCorePkg.sv
package rvCorePkg;

    // alu operation select, codes follow the controller encoding
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SUB   = 5'b00001,
        ALU_MUL   = 5'b00010,   // low word of the product
        ALU_SLL   = 5'b00100,
        ALU_SRL   = 5'b00101,
        ALU_OR    = 5'b01000,
        ALU_XOR   = 5'b01001,
        ALU_SLT   = 5'b01010,   // signed compare
        ALU_AND   = 5'b01011,
        ALU_PASSB = 5'b10000    // lui, second operand straight through
    } aluCtrlE;

    // write-back source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10         // link value for jal
    } resultSrcE;

    // immediate format
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrcE;

endpackage

// File: verilog/decodeStage.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module decodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  logic [`XLEN-1:0]     instr,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1Data,
    input  logic [`XLEN-1:0]     rs2Data,
    output logic                 exValid,
    output rvCorePkg::aluCtrlE   aluCtrl,
    output logic                 aluSrcImm,
    output logic                 memReadD,
    output logic                 memWriteD,
    output logic                 regWriteD,
    output logic                 branchD,
    output logic                 branchNe,
    output logic                 jumpD,
    output rvCorePkg::resultSrcE resultSrcD,
    output logic [`XLEN-1:0]     imm,
    output logic [`XLEN-1:0]     opA,
    output logic [`XLEN-1:0]     opB,
    output logic [`XLEN-1:0]     pcD,
    output logic [`REGW-1:0]     rdD
);
    import rvCorePkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`REGW-1:0] rd;
    logic [16:0]      aluKey;   // opcode + funct3 + funct7

    logic             srcImm;
    logic             memRd;
    logic             memWr;
    logic             regWr;
    logic             isBranch;
    logic             isJump;
    resultSrcE        resSrc;
    immSrcE           immSrc;
    aluCtrlE          aluOp;
    logic [`XLEN-1:0] immVal;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign aluKey = {opcode, funct3, funct7};

    always_comb begin : mainDecoder
        srcImm   = 1'b0;    // unknown opcode leaves everything low
        memRd    = 1'b0;
        memWr    = 1'b0;
        regWr    = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        resSrc   = RES_ALU;
        immSrc   = IMM_I;
        case (opcode)
            `OP_LOAD: begin
                srcImm = 1'b1;
                memRd  = 1'b1;
                regWr  = 1'b1;
                resSrc = RES_MEM;
            end
            `OP_STORE: begin
                srcImm = 1'b1;
                memWr  = 1'b1;
                immSrc = IMM_S;
            end
            `OP_RTYPE:  regWr = 1'b1;
            `OP_ITYPE: begin
                srcImm = 1'b1;
                regWr  = 1'b1;
            end
            `OP_BRANCH: begin
                isBranch = 1'b1;
                immSrc   = IMM_B;
            end
            `OP_JAL: begin
                isJump = 1'b1;
                regWr  = 1'b1;
                resSrc = RES_PC4;
                immSrc = IMM_J;
            end
            `OP_LUI: begin
                srcImm = 1'b1;
                regWr  = 1'b1;
                immSrc = IMM_U;
            end
            default: ;
        endcase
    end

    always_comb begin : aluDecoder
        casez (aluKey)
            {`OP_RTYPE, 3'b000, 7'b0000000}: aluOp = ALU_ADD;
            {`OP_RTYPE, 3'b000, 7'b0100000}: aluOp = ALU_SUB;
            {`OP_RTYPE, 3'b000, 7'b0000001}: aluOp = ALU_MUL;
            {`OP_RTYPE, 3'b001, 7'b0000000}: aluOp = ALU_SLL;
            {`OP_RTYPE, 3'b010, 7'b0000000}: aluOp = ALU_SLT;
            {`OP_RTYPE, 3'b100, 7'b0000000}: aluOp = ALU_XOR;
            {`OP_RTYPE, 3'b101, 7'b0000000}: aluOp = ALU_SRL;
            {`OP_RTYPE, 3'b110, 7'b0000000}: aluOp = ALU_OR;
            {`OP_RTYPE, 3'b111, 7'b0000000}: aluOp = ALU_AND;
            {`OP_BRANCH, 10'b??????????}:    aluOp = ALU_SUB;   // compare by subtract
            {`OP_LUI, 10'b??????????}:       aluOp = ALU_PASSB;
            default:                         aluOp = ALU_ADD;   // addi, lw, sw address
        endcase
    end

    always_comb begin : immGen
        case (immSrc)
            IMM_I:   immVal = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            IMM_S:   immVal = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   immVal = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                               instr[30:25], instr[11:8], 1'b0};
            IMM_J:   immVal = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                               instr[20], instr[30:21], 1'b0};
            IMM_U:   immVal = {instr[31:12], {(`XLEN-20){1'b0}}};
            default: immVal = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid   <= 1'b0;
            memReadD  <= 1'b0;
            memWriteD <= 1'b0;
            regWriteD <= 1'b0;
            branchD   <= 1'b0;
            jumpD     <= 1'b0;
        end else begin
            exValid   <= instrValid;
            memReadD  <= memRd;
            memWriteD <= memWr;
            regWriteD <= regWr & (rd != '0);    // x0 is never written
            branchD   <= isBranch;
            jumpD     <= isJump;
        end
    end

    always_ff @(posedge clk) begin
        aluCtrl    <= aluOp;
        aluSrcImm  <= srcImm;
        branchNe   <= funct3[0];    // bne has funct3 001
        resultSrcD <= resSrc;
        imm        <= immVal;
        opA        <= rs1Data;
        opB        <= rs2Data;
        pcD        <= pc;
        rdD        <= rd;
    end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module executeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exValid,
    input  rvCorePkg::aluCtrlE   aluCtrl,
    input  logic                 aluSrcImm,
    input  logic                 memReadD,
    input  logic                 memWriteD,
    input  logic                 regWriteD,
    input  logic                 branchD,
    input  logic                 branchNe,
    input  logic                 jumpD,
    input  rvCorePkg::resultSrcE resultSrcD,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     opA,
    input  logic [`XLEN-1:0]     opB,
    input  logic [`XLEN-1:0]     pcD,
    input  logic [`REGW-1:0]     rdD,
    output logic                 memRead,
    output logic                 memWrite,
    output logic [`XLEN-1:0]     memAddr,
    output logic [`XLEN-1:0]     storeData,
    output logic                 redirect,
    output logic [`XLEN-1:0]     redirectPc,
    output logic                 rsValid,
    output logic [`XLEN-1:0]     aluResult,
    output logic [`XLEN-1:0]     pc4,
    output rvCorePkg::resultSrcE resultSrcE,
    output logic                 regWriteE,
    output logic [`REGW-1:0]     rdE
);
    import rvCorePkg::*;

    localparam int               SHW         = $clog2(`XLEN);
    localparam logic [`XLEN-1:0] INSTR_BYTES = 4;

    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] diff;
    logic [`XLEN-1:0] target;
    logic             equal;
    logic             taken;
    logic             redirectNext;

    assign srcB = aluSrcImm ? imm : opB;

    always_comb begin : alu
        case (aluCtrl)
            ALU_ADD:   aluOut = opA + srcB;
            ALU_SUB:   aluOut = opA - srcB;
            ALU_MUL:   aluOut = opA * srcB;     // keeps the low word
            ALU_SLL:   aluOut = opA << srcB[SHW-1:0];
            ALU_SRL:   aluOut = opA >> srcB[SHW-1:0];
            ALU_OR:    aluOut = opA | srcB;
            ALU_XOR:   aluOut = opA ^ srcB;
            ALU_AND:   aluOut = opA & srcB;
            ALU_SLT:   aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(srcB)};
            ALU_PASSB: aluOut = srcB;
            default:   aluOut = opA + srcB;
        endcase
    end

    // branch compare uses the register pair, never the immediate
    assign diff         = opA - opB;
    assign equal        = (diff == '0);
    assign taken        = branchD & (equal ^ branchNe);
    assign redirectNext = exValid & (taken | jumpD);
    assign target       = pcD + imm;    // same adder for beq, bne and jal

    always_ff @(posedge clk) begin
        if (rst) begin
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            redirect  <= 1'b0;
            rsValid   <= 1'b0;
            regWriteE <= 1'b0;
        end else begin
            memRead   <= exValid & memReadD;
            memWrite  <= exValid & memWriteD;
            redirect  <= redirectNext;
            rsValid   <= exValid;
            regWriteE <= exValid & regWriteD;
        end
    end

    always_ff @(posedge clk) begin
        aluResult  <= aluOut;
        storeData  <= opB;
        redirectPc <= target;
        pc4        <= pcD + INSTR_BYTES;
        resultSrcE <= resultSrcD;
        rdE        <= rdD;
    end

    assign memAddr = aluResult;     // address comes out of the alu register

    // a store never also writes back, checked across decode and execute
    noStoreWriteBack : assert property (@(posedge clk) disable iff (rst)
        !(memWrite && regWriteE));

endmodule

// File: verilog/resultStage.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module resultStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rsValid,
    input  logic [`XLEN-1:0]     aluResult,
    input  logic [`XLEN-1:0]     pc4,
    input  logic [`XLEN-1:0]     readData,
    input  rvCorePkg::resultSrcE resultSrcE,
    input  logic                 regWriteE,
    input  logic [`REGW-1:0]     rdE,
    output logic                 wbEn,
    output logic [`REGW-1:0]     wbRd,
    output logic [`XLEN-1:0]     wbData
);
    import rvCorePkg::*;

    logic [`XLEN-1:0] wbNext;

    always_comb begin
        case (resultSrcE)
            RES_MEM: wbNext = readData;     // memory answers in this same cycle
            RES_PC4: wbNext = pc4;
            default: wbNext = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbEn <= 1'b0;
        end else begin
            wbEn <= rsValid & regWriteE;
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= rdE;
        wbData <= wbNext;
    end

    // x0 suppression happens two stages back in decode
    noWriteToZero : assert property (@(posedge clk) disable iff (rst)
        wbEn |-> (wbRd != '0));

endmodule

// File: verilog/rvSliceTop.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module rvSliceTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] readData,
    output logic             memRead,
    output logic             memWrite,
    output logic [`XLEN-1:0] memAddr,
    output logic [`XLEN-1:0] storeData,
    output logic             redirect,
    output logic [`XLEN-1:0] redirectPc,
    output logic             wbEn,
    output logic [`REGW-1:0] wbRd,
    output logic [`XLEN-1:0] wbData
);
    import rvCorePkg::*;

    // decode to execute
    logic                 exValid;
    aluCtrlE              aluCtrl;
    logic                 aluSrcImm;
    logic                 memReadD;
    logic                 memWriteD;
    logic                 regWriteD;
    logic                 branchD;
    logic                 branchNe;
    logic                 jumpD;
    rvCorePkg::resultSrcE resultSrcD;
    logic [`XLEN-1:0]     imm;
    logic [`XLEN-1:0]     opA;
    logic [`XLEN-1:0]     opB;
    logic [`XLEN-1:0]     pcD;
    logic [`REGW-1:0]     rdD;

    // execute to result, the signal shares its name with the type
    logic                 rsValid;
    logic [`XLEN-1:0]     aluResult;
    logic [`XLEN-1:0]     pc4;
    rvCorePkg::resultSrcE resultSrcE;
    logic                 regWriteE;
    logic [`REGW-1:0]     rdE;

    decodeStage u_decodeStage (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .exValid    (exValid),
        .aluCtrl    (aluCtrl),
        .aluSrcImm  (aluSrcImm),
        .memReadD   (memReadD),
        .memWriteD  (memWriteD),
        .regWriteD  (regWriteD),
        .branchD    (branchD),
        .branchNe   (branchNe),
        .jumpD      (jumpD),
        .resultSrcD (resultSrcD),
        .imm        (imm),
        .opA        (opA),
        .opB        (opB),
        .pcD        (pcD),
        .rdD        (rdD)
    );

    executeStage u_executeStage (
        .clk        (clk),
        .rst        (rst),
        .exValid    (exValid),
        .aluCtrl    (aluCtrl),
        .aluSrcImm  (aluSrcImm),
        .memReadD   (memReadD),
        .memWriteD  (memWriteD),
        .regWriteD  (regWriteD),
        .branchD    (branchD),
        .branchNe   (branchNe),
        .jumpD      (jumpD),
        .resultSrcD (resultSrcD),
        .imm        (imm),
        .opA        (opA),
        .opB        (opB),
        .pcD        (pcD),
        .rdD        (rdD),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .storeData  (storeData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .rsValid    (rsValid),
        .aluResult  (aluResult),
        .pc4        (pc4),
        .resultSrcE (resultSrcE),
        .regWriteE  (regWriteE),
        .rdE        (rdE)
    );

    resultStage u_resultStage (
        .clk        (clk),
        .rst        (rst),
        .rsValid    (rsValid),
        .aluResult  (aluResult),
        .pc4        (pc4),
        .readData   (readData),
        .resultSrcE (resultSrcE),
        .regWriteE  (regWriteE),
        .rdE        (rdE),
        .wbEn       (wbEn),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

endmodule

// File: testbench/rvSliceTb.sv
`timescale 1ns/100ps
`include "rvCore_macros.svh"

module rvSliceTb;

    localparam int STREAM_LEN     = 200;
    localparam int ISSUED         = 27 + 5 + 5 + 6 + STREAM_LEN;   // directed + random
    localparam int TIMEOUT_CYCLES = 4 * ISSUED + 100;
    localparam int MEM_WORDS      = 64;

    // what one issued instruction must show at the 2- and 3-edge offsets
    typedef struct packed {
        logic [31:0]        issue;      // cycle the inputs were driven
        logic               memRd;
        logic               memWr;
        logic [`XLEN-1:0]   addr;
        logic [`XLEN-1:0]   stData;
        logic               redir;
        logic [`XLEN-1:0]   redirPc;
        logic               wbEn;
        logic [`REGW-1:0]   rd;
        logic [`XLEN-1:0]   wbData;
    } expectT;

    logic             clk;
    logic             rst;
    logic             instrValid;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] readData;
    logic             memRead;
    logic             memWrite;
    logic [`XLEN-1:0] memAddr;
    logic [`XLEN-1:0] storeData;
    logic             redirect;
    logic [`XLEN-1:0] redirectPc;
    logic             wbEn;
    logic [`REGW-1:0] wbRd;
    logic [`XLEN-1:0] wbData;

    logic [31:0]      cycleCnt = '0;
    int               errCount = 0;
    int               seed     = 31782;
    logic [31:0]      dataMem [MEM_WORDS];  // memory seen by the DUT
    logic [31:0]      refMem  [MEM_WORDS];  // same memory as the model expects it
    expectT           memQ [$];
    expectT           wbQ [$];
    expectT           memItem;
    expectT           wbItem;

    rvSliceTop u_rvSliceTop (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .readData   (readData),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .storeData  (storeData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbEn       (wbEn),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] fillWord(input int idx);
        return 32'hA500_0000 ^ (32'(idx) * 32'h0102_0409);
    endfunction

    assign readData = dataMem[memAddr[7:2]];    // combinational read, word addressed

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dataMem[i] <= fillWord(i);
            end
        end else if (memWrite) begin
            dataMem[memAddr[7:2]] <= storeData;
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 32'd1;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errCount++;
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // outputs settle at the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (memQ.size() > 0 && memQ[0].issue + 32'd2 == cycleCnt) begin
            memItem = memQ.pop_front();
            checkValue("memRead", {31'b0, memRead}, {31'b0, memItem.memRd});
            checkValue("memWrite", {31'b0, memWrite}, {31'b0, memItem.memWr});
            checkValue("redirect", {31'b0, redirect}, {31'b0, memItem.redir});
            if (memItem.memRd || memItem.memWr) begin
                checkValue("memAddr", memAddr, memItem.addr);
            end
            if (memItem.memWr) begin
                checkValue("storeData", storeData, memItem.stData);
            end
            if (memItem.redir) begin
                checkValue("redirectPc", redirectPc, memItem.redirPc);
            end
        end
        if (wbQ.size() > 0 && wbQ[0].issue + 32'd3 == cycleCnt) begin
            wbItem = wbQ.pop_front();
            checkValue("wbEn", {31'b0, wbEn}, {31'b0, wbItem.wbEn});
            if (wbItem.wbEn) begin
                checkValue("wbRd", {27'b0, wbRd}, {27'b0, wbItem.rd});
                checkValue("wbData", wbData, wbItem.wbData);
            end
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    // op index: add sub and or xor slt sll srl mul
    function automatic logic [31:0] encR(input int op, input logic [4:0] rd);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (op == 1) ? 7'b0100000 : ((op == 8) ? 7'b0000001 : 7'b0000000);
        case (op)
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            4:       f3 = 3'b100;
            5:       f3 = 3'b010;
            6:       f3 = 3'b001;
            7:       f3 = 3'b101;
            default: f3 = 3'b000;   // add, sub, mul
        endcase
        return {f7, 5'd2, 5'd1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic logic [31:0] aluModel(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return a << b[4:0];
            7:       return a >> b[4:0];
            default: return a * b;  // low word only
        endcase
    endfunction

    function automatic expectT noEffect();
        expectT e;
        e = '0;
        return e;
    endfunction

    task automatic stepCycle(input logic valid, input logic [31:0] word,
                             input logic [31:0] pcVal, input logic [31:0] a,
                             input logic [31:0] b, input expectT e);
        @(posedge clk);
        #2;
        instrValid = valid;
        instr      = word;
        pc         = pcVal;
        rs1Data    = a;
        rs2Data    = b;
        e.issue    = cycleCnt;
        memQ.push_back(e);
        wbQ.push_back(e);
    endtask

    // a store word with valid low must leave memory alone
    task automatic idleStep();
        stepCycle(1'b0, encS(12'h004, 5'd2, 5'd1), 32'h0, 32'h40, 32'h1111_2222, noEffect());
    endtask

    task automatic drain();
        repeat (3) idleStep();
    endtask

    task automatic issueR(input int op, input logic [4:0] rd, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] pcVal);
        expectT e;
        e        = noEffect();
        e.wbEn   = (rd != 5'd0);
        e.rd     = rd;
        e.wbData = aluModel(op, a, b);
        stepCycle(1'b1, encR(op, rd), pcVal, a, b, e);
    endtask

    task automatic issueAddi(input logic [4:0] rd, input logic [31:0] a,
                             input logic [11:0] imm, input logic [31:0] pcVal);
        expectT e;
        e        = noEffect();
        e.wbEn   = (rd != 5'd0);
        e.rd     = rd;
        e.wbData = a + sext12(imm);
        stepCycle(1'b1, encI(imm, 5'd3, 3'b000, rd, `OP_ITYPE), pcVal, a, ~a, e);
    endtask

    task automatic issueLui(input logic [4:0] rd, input logic [19:0] imm,
                            input logic [31:0] pcVal);
        expectT e;
        e        = noEffect();
        e.wbEn   = (rd != 5'd0);
        e.rd     = rd;
        e.wbData = {imm, 12'h000};
        stepCycle(1'b1, {imm, rd, `OP_LUI}, pcVal, 32'h0BAD_0001, 32'h0BAD_0002, e);
    endtask

    task automatic issueLw(input logic [4:0] rd, input logic [31:0] base,
                           input logic [11:0] imm, input logic [31:0] pcVal);
        expectT e;
        e        = noEffect();
        e.memRd  = 1'b1;
        e.addr   = base + sext12(imm);
        e.wbEn   = (rd != 5'd0);
        e.rd     = rd;
        e.wbData = refMem[e.addr[7:2]];
        stepCycle(1'b1, encI(imm, 5'd4, 3'b010, rd, `OP_LOAD), pcVal, base, 32'h0, e);
    endtask

    task automatic issueSw(input logic [31:0] base, input logic [31:0] data,
                           input logic [11:0] imm, input logic [31:0] pcVal);
        expectT e;
        e        = noEffect();
        e.memWr  = 1'b1;
        e.addr   = base + sext12(imm);
        e.stData = data;
        refMem[e.addr[7:2]] = data;
        stepCycle(1'b1, encS(imm, 5'd6, 5'd5), pcVal, base, data, e);
    endtask

    task automatic issueBranch(input logic isNe, input logic [31:0] a, input logic [31:0] b,
                               input logic [12:0] imm, input logic [31:0] pcVal);
        expectT e;
        e         = noEffect();
        e.redir   = isNe ? (a != b) : (a == b);
        e.redirPc = pcVal + {{19{imm[12]}}, imm[12:1], 1'b0};
        stepCycle(1'b1, encB(imm, 5'd8, 5'd7, {2'b00, isNe}), pcVal, a, b, e);
    endtask

    task automatic issueJal(input logic [4:0] rd, input logic [20:0] imm,
                            input logic [31:0] pcVal);
        expectT e;
        e         = noEffect();
        e.redir   = 1'b1;
        e.redirPc = pcVal + {{11{imm[20]}}, imm[20:1], 1'b0};
        e.wbEn    = (rd != 5'd0);
        e.rd      = rd;
        e.wbData  = pcVal + 32'd4;  // link
        stepCycle(1'b1, encJ(imm, rd), pcVal, 32'h0, 32'h0, e);
    endtask

    task automatic testRType();
        logic [31:0] aVals [3];
        logic [31:0] bVals [3];
        logic [31:0] pcVal;
        aVals = '{32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};
        bVals = '{32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0023};  // shift uses low 5 bits
        pcVal = 32'h0000_1000;
        for (int op = 0; op < 9; op++) begin
            for (int k = 0; k < 3; k++) begin
                issueR(op, 5'(op + 1), aVals[k], bVals[k], pcVal);
                pcVal += 32'd4;
            end
        end
        drain();
    endtask

    task automatic testImmediates();
        issueAddi(5'd5, 32'd100, 12'hFFF, 32'h0000_1100);
        issueAddi(5'd6, 32'd0, 12'h800, 32'h0000_1104);
        issueLui(5'd7, 20'hABCDE, 32'h0000_1108);
        issueLui(5'd0, 20'h12345, 32'h0000_110C);     // x0, no write-back
        issueAddi(5'd0, 32'h55, 12'h001, 32'h0000_1110);
        drain();
    endtask

    task automatic testMemory();
        issueSw(32'h0000_0100, 32'hCAFE_F00D, 12'h008, 32'h0000_1200);
        issueLw(5'd9, 32'h0000_0100, 12'h008, 32'h0000_1204);
        issueSw(32'h0000_0140, 32'h0123_4567, 12'hFFC, 32'h0000_1208);
        issueLw(5'd10, 32'h0000_013C, 12'h000, 32'h0000_120C);
        issueLw(5'd11, 32'h0000_0000, 12'h020, 32'h0000_1210);   // untouched word
        drain();
    endtask

    task automatic testControlFlow();
        issueBranch(1'b0, 32'h55, 32'h55, 13'h0010, 32'h0000_3000);
        issueBranch(1'b0, 32'h1, 32'h2, 13'h0010, 32'h0000_3004);
        issueBranch(1'b1, 32'h1, 32'h2, 13'h1FF8, 32'h0000_3008);
        issueBranch(1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 13'h0020, 32'h0000_300C);
        issueJal(5'd1, 21'h000100, 32'h0000_3010);
        issueJal(5'd0, 21'h1FFFF0, 32'h0000_3014);
        drain();
    endtask

    task automatic testStream();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pcVal;
        logic [6:0]  badOp;
        int          kind;
        pcVal = 32'h0000_2000;
        for (int n = 0; n < STREAM_LEN; n++) begin
            r    = $random(seed);
            a    = $random(seed);
            b    = $random(seed);
            kind = int'(r[3:0]);
            if (r[17:16] == 2'b00) begin
                b = a;  // lets branches see equal operands
            end
            case (kind)
                4, 5:   issueAddi(r[12:8], a, r[31:20], pcVal);
                6:      issueLui(r[12:8], r[31:12], pcVal);
                7, 8:   issueLw(r[12:8], a, r[31:20], pcVal);
                9, 10:  issueSw(a, b, r[31:20], pcVal);
                11, 12: issueBranch(r[13], a, b, r[31:19], pcVal);
                13:     issueJal(r[12:8], r[31:11], pcVal);
                14: begin
                    case (r[5:4])
                        2'd0:    badOp = 7'b0001111;
                        2'd1:    badOp = 7'b1110011;
                        2'd2:    badOp = 7'b0010111;
                        default: badOp = 7'b1100111;
                    endcase
                    stepCycle(1'b1, {r[31:7], badOp}, pcVal, a, b, noEffect());
                end
                default: issueR(int'(r[31:20]) % 9, r[12:8], a, b, pcVal);
            endcase
            pcVal += 32'd4;
        end
        drain();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        rs1Data    = '0;
        rs2Data    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            refMem[i] = fillWord(i);
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        testRType();
        testImmediates();
        testMemory();
        testControlFlow();
        testStream();
        while (wbQ.size() != 0) begin
            @(negedge clk);
        end
        #1;
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/rvCorePkg.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/rvSliceTop.sv
testbench/rvSliceTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rvSliceTb
FILELIST  = sources.f

BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) verilog/rvCore_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "RESULT: FAIL, no pass line in $(LOG)"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
